// File: alu_unit.sv
`timescale 1ns/10ps
module alu_unit import exec_pkg::*;
(
	input  opcode_t opcode,
	input  funct3_t funct3,
	input  funct7_t funct7,
	input  xlen_t   op_a,
	input  xlen_t   op_b,
	input  xlen_t   imm,
	input  xlen_t   pc,
	output xlen_t   result,
	output logic    writes_rd   // Not masked for x0 here
);
	xlen_t              opnd;      // Second operand, register or immediate
	logic [SHAMT_W-1:0] shamt;
	xlen_t              sra_val;
	xlen_t              alu_out;
	logic               f7_base;
	logic               f7_alt;
	logic               op_legal;

	assign opnd    = (opcode == OP) ? op_b : imm;
	assign shamt   = opnd[SHAMT_W-1:0];
	assign sra_val = $signed(op_a) >>> shamt;
	assign f7_base = (funct7 == FN7_BASE);
	assign f7_alt  = (funct7 == FN7_ALT);

	// For OP, only ADD/SUB and SRL/SRA accept the alternate funct7
	assign op_legal = f7_base ||
		(f7_alt && ((funct3 == FN3_ADD_SUB) || (funct3 == FN3_SRL_SRA)));

	////////////////////////////////////////////////////////////
	// Shared arithmetic for OP and OP_IMM
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (funct3)
			FN3_ADD_SUB:
				alu_out = (opcode == OP && f7_alt) ? op_a - opnd : op_a + opnd;
			FN3_SLL:     alu_out = op_a << shamt;
			FN3_SLT:     alu_out = xlen_t'($signed(op_a) < $signed(opnd));
			FN3_SLTU:    alu_out = xlen_t'(op_a < opnd);
			FN3_XOR:     alu_out = op_a ^ opnd;
			FN3_SRL_SRA: alu_out = f7_alt ? sra_val : op_a >> shamt;
			FN3_OR:      alu_out = op_a | opnd;
			FN3_AND:     alu_out = op_a & opnd;
			default:     alu_out = '0;
		endcase
	end

	always_comb
	begin
		result    = '0;
		writes_rd = 1'b1;
		case (opcode)
			OP:     result = op_legal ? alu_out : '0;
			OP_IMM: result = alu_out;
			LUI:    result = imm;
			AUIPC:  result = pc + imm;
			JAL,
			JALR:   result = pc + xlen_t'(PC_INC);   // Link value
			default:
				writes_rd = 1'b0;   // Branches, loads and stores
		endcase
	end

endmodule

// File: branch_mem_unit.sv
`timescale 1ns/10ps
module branch_mem_unit import exec_pkg::*;
(
	input  opcode_t opcode,
	input  funct3_t funct3,
	input  xlen_t   op_a,
	input  xlen_t   op_b,
	input  xlen_t   imm,
	input  xlen_t   pc,
	output logic    branch_en,
	output xlen_t   branch_addr,   // Zero when not taken
	output logic    mem_rd,
	output logic    mem_wr,
	output xlen_t   mem_addr,
	output xlen_t   mem_data,
	output funct3_t mem_size
);
	logic  taken;
	xlen_t eff_addr;   // rs1 + imm for loads, stores and JALR

	assign eff_addr = op_a + imm;

	// Branch condition
	always_comb
	begin
		case (funct3)
			FN3_BEQ:  taken = (op_a == op_b);
			FN3_BNE:  taken = (op_a != op_b);
			FN3_BLT:  taken = ($signed(op_a) <  $signed(op_b));
			FN3_BGE:  taken = ($signed(op_a) >= $signed(op_b));
			FN3_BLTU: taken = (op_a <  op_b);
			FN3_BGEU: taken = (op_a >= op_b);
			default:  taken = 1'b0;
		endcase
	end

	always_comb
	begin
		branch_en   = 1'b0;
		branch_addr = '0;
		mem_rd      = 1'b0;
		mem_wr      = 1'b0;
		mem_addr    = '0;
		mem_data    = '0;
		mem_size    = '0;
		case (opcode)
			BRANCH:
			begin
				branch_en   = taken;
				branch_addr = taken ? pc + imm : '0;
			end
			JAL:
			begin
				branch_en   = 1'b1;
				branch_addr = pc + imm;
			end
			JALR:
			begin
				branch_en   = 1'b1;
				branch_addr = eff_addr & ~xlen_t'(1);   // Clear bit 0
			end
			LOAD:
			begin
				mem_rd   = 1'b1;
				mem_addr = eff_addr;
				mem_size = funct3;
			end
			STORE:
			begin
				mem_wr   = 1'b1;
				mem_addr = eff_addr;
				mem_size = funct3;
				case (funct3)
					FN3_SB:  mem_data = xlen_t'(op_b[7:0]);
					FN3_SH:  mem_data = xlen_t'(op_b[15:0]);
					FN3_SW:  mem_data = op_b;
					default: mem_data = '0;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: exec_pkg.sv
package exec_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 7;
	localparam int FUNCT3_W   = 3;
	localparam int FUNCT7_W   = 7;
	localparam int SHAMT_W    = 5;
	localparam int PC_INC     = 4;   // Link offset for JAL and JALR

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [FUNCT3_W-1:0]   funct3_t;
	typedef logic [FUNCT7_W-1:0]   funct7_t;

	// RV32I major opcodes handled by the execute stage
	typedef enum logic [OPCODE_W-1:0]
	{
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		BRANCH = 7'b1100011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_t;

	////////////////////////////////////////////////////////////
	// funct3 and funct7 codes
	////////////////////////////////////////////////////////////
	localparam funct3_t FN3_ADD_SUB = 3'b000;
	localparam funct3_t FN3_SLL     = 3'b001;
	localparam funct3_t FN3_SLT     = 3'b010;
	localparam funct3_t FN3_SLTU    = 3'b011;
	localparam funct3_t FN3_XOR     = 3'b100;
	localparam funct3_t FN3_SRL_SRA = 3'b101;
	localparam funct3_t FN3_OR      = 3'b110;
	localparam funct3_t FN3_AND     = 3'b111;

	// Branch conditions
	localparam funct3_t FN3_BEQ  = 3'b000;
	localparam funct3_t FN3_BNE  = 3'b001;
	localparam funct3_t FN3_BLT  = 3'b100;
	localparam funct3_t FN3_BGE  = 3'b101;
	localparam funct3_t FN3_BLTU = 3'b110;
	localparam funct3_t FN3_BGEU = 3'b111;

	// Store widths
	localparam funct3_t FN3_SB = 3'b000;
	localparam funct3_t FN3_SH = 3'b001;
	localparam funct3_t FN3_SW = 3'b010;

	localparam funct7_t FN7_BASE = 7'b0000000;
	localparam funct7_t FN7_ALT  = 7'b0100000;   // SUB and SRA

endpackage

// File: exec_stage.sv
`timescale 1ns/10ps
module exec_stage import exec_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      buf_valid,
	input  xlen_t     head_pc,
	input  opcode_t   head_opcode,
	input  funct3_t   head_funct3,
	input  funct7_t   head_funct7,
	input  reg_addr_t head_rs1_addr,
	input  reg_addr_t head_rs2_addr,
	input  reg_addr_t head_rd_addr,
	input  xlen_t     head_rs1_data,
	input  xlen_t     head_rs2_data,
	input  xlen_t     head_imm,
	input  logic      can_send,
	output logic      buf_pop,
	output logic      out_valid,
	output logic      rd_we,
	output reg_addr_t rd_addr,
	output xlen_t     rd_data,
	output logic      branch_en,
	output xlen_t     branch_addr,
	output logic      mem_rd,
	output logic      mem_wr,
	output xlen_t     mem_addr,
	output xlen_t     mem_data,
	output funct3_t   mem_size
);
	logic    fwd_valid;   // Last popped instruction wrote a nonzero rd
	xlen_t   op_a;
	xlen_t   op_b;
	xlen_t   alu_result;
	logic    alu_writes_rd;
	logic    wr_rd;
	logic    bm_branch_en;
	xlen_t   bm_branch_addr;
	logic    bm_mem_rd;
	logic    bm_mem_wr;
	xlen_t   bm_mem_addr;
	xlen_t   bm_mem_data;
	funct3_t bm_mem_size;

	assign buf_pop = buf_valid && can_send;
	assign wr_rd   = alu_writes_rd && (head_rd_addr != '0);

	// rd_addr and rd_data hold the last result between pops
	assign op_a = (fwd_valid && head_rs1_addr == rd_addr) ? rd_data : head_rs1_data;
	assign op_b = (fwd_valid && head_rs2_addr == rd_addr) ? rd_data : head_rs2_data;

	alu_unit u_alu
	(
		.opcode    (head_opcode),
		.funct3    (head_funct3),
		.funct7    (head_funct7),
		.op_a      (op_a),
		.op_b      (op_b),
		.imm       (head_imm),
		.pc        (head_pc),
		.result    (alu_result),
		.writes_rd (alu_writes_rd)
	);

	branch_mem_unit u_branch_mem
	(
		.opcode      (head_opcode),
		.funct3      (head_funct3),
		.op_a        (op_a),
		.op_b        (op_b),
		.imm         (head_imm),
		.pc          (head_pc),
		.branch_en   (bm_branch_en),
		.branch_addr (bm_branch_addr),
		.mem_rd      (bm_mem_rd),
		.mem_wr      (bm_mem_wr),
		.mem_addr    (bm_mem_addr),
		.mem_data    (bm_mem_data),
		.mem_size    (bm_mem_size)
	);

	////////////////////////////////////////////////////////////
	// Result register, loaded on pop
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			rd_we     <= 1'b0;
			branch_en <= 1'b0;
			mem_rd    <= 1'b0;
			mem_wr    <= 1'b0;
			fwd_valid <= 1'b0;
		end
		else
		begin
			out_valid <= buf_pop;   // Single cycle pulse per pop
			rd_we     <= buf_pop && wr_rd;
			branch_en <= buf_pop && bm_branch_en;
			mem_rd    <= buf_pop && bm_mem_rd;
			mem_wr    <= buf_pop && bm_mem_wr;
			if (buf_pop)
				fwd_valid <= wr_rd;
		end
	end

	always_ff @(posedge clk)
	begin
		if (buf_pop)
		begin
			rd_addr     <= head_rd_addr;
			rd_data     <= alu_result;
			branch_addr <= bm_branch_addr;
			mem_addr    <= bm_mem_addr;
			mem_data    <= bm_mem_data;
			mem_size    <= bm_mem_size;
		end
	end

endmodule

// File: instr_exec_top.sv
`timescale 1ns/10ps
module instr_exec_top import exec_pkg::*;
#(
	parameter int INPUT_DEPTH = 4,
	parameter int OUT_CREDITS = 2
)
(
	input  logic      clk,
	input  logic      rst_n,
	// Issue side
	input  logic      in_valid,
	input  xlen_t     pc,
	input  opcode_t   opcode,
	input  funct3_t   funct3,
	input  funct7_t   funct7,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  xlen_t     rs1_data,
	input  xlen_t     rs2_data,
	input  reg_addr_t in_rd_addr,   // Destination of the issued instruction
	input  xlen_t     imm,
	output logic      in_credit,
	// Result side
	output logic      out_valid,
	output logic      rd_we,
	output reg_addr_t rd_addr,
	output xlen_t     rd_data,
	output logic      branch_en,
	output xlen_t     branch_addr,
	output logic      mem_rd,
	output logic      mem_wr,
	output xlen_t     mem_addr,
	output xlen_t     mem_data,
	output funct3_t   mem_size,
	input  logic      out_credit
);
	logic      buf_valid;
	logic      buf_pop;
	logic      can_send;
	xlen_t     head_pc;
	opcode_t   head_opcode;
	funct3_t   head_funct3;
	funct7_t   head_funct7;
	reg_addr_t head_rs1_addr;
	reg_addr_t head_rs2_addr;
	reg_addr_t head_rd_addr;
	xlen_t     head_rs1_data;
	xlen_t     head_rs2_data;
	xlen_t     head_imm;

	issue_buffer #(.INPUT_DEPTH(INPUT_DEPTH)) u_issue_buffer
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.pc            (pc),
		.opcode        (opcode),
		.funct3        (funct3),
		.funct7        (funct7),
		.rs1_addr      (rs1_addr),
		.rs2_addr      (rs2_addr),
		.rd_addr       (in_rd_addr),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.imm           (imm),
		.buf_pop       (buf_pop),
		.buf_valid     (buf_valid),
		.head_pc       (head_pc),
		.head_opcode   (head_opcode),
		.head_funct3   (head_funct3),
		.head_funct7   (head_funct7),
		.head_rs1_addr (head_rs1_addr),
		.head_rs2_addr (head_rs2_addr),
		.head_rd_addr  (head_rd_addr),
		.head_rs1_data (head_rs1_data),
		.head_rs2_data (head_rs2_data),
		.head_imm      (head_imm),
		.in_credit     (in_credit)
	);

	exec_stage u_exec_stage
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.buf_valid     (buf_valid),
		.head_pc       (head_pc),
		.head_opcode   (head_opcode),
		.head_funct3   (head_funct3),
		.head_funct7   (head_funct7),
		.head_rs1_addr (head_rs1_addr),
		.head_rs2_addr (head_rs2_addr),
		.head_rd_addr  (head_rd_addr),
		.head_rs1_data (head_rs1_data),
		.head_rs2_data (head_rs2_data),
		.head_imm      (head_imm),
		.can_send      (can_send),
		.buf_pop       (buf_pop),
		.out_valid     (out_valid),
		.rd_we         (rd_we),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.branch_en     (branch_en),
		.branch_addr   (branch_addr),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_size      (mem_size)
	);

	result_sender #(.OUT_CREDITS(OUT_CREDITS)) u_result_sender
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.out_valid  (out_valid),
		.out_credit (out_credit),
		.can_send   (can_send)
	);

endmodule

// File: issue_buffer.sv
`timescale 1ns/10ps
module issue_buffer import exec_pkg::*;
#(
	parameter int INPUT_DEPTH = 4
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  xlen_t     pc,
	input  opcode_t   opcode,
	input  funct3_t   funct3,
	input  funct7_t   funct7,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  reg_addr_t rd_addr,
	input  xlen_t     rs1_data,
	input  xlen_t     rs2_data,
	input  xlen_t     imm,
	input  logic      buf_pop,
	output logic      buf_valid,
	output xlen_t     head_pc,
	output opcode_t   head_opcode,
	output funct3_t   head_funct3,
	output funct7_t   head_funct7,
	output reg_addr_t head_rs1_addr,
	output reg_addr_t head_rs2_addr,
	output reg_addr_t head_rd_addr,
	output xlen_t     head_rs1_data,
	output xlen_t     head_rs2_data,
	output xlen_t     head_imm,
	output logic      in_credit     // One pulse per freed entry
);
	localparam int PTR_W = (INPUT_DEPTH > 1) ? $clog2(INPUT_DEPTH) : 1;
	localparam int CNT_W = $clog2(INPUT_DEPTH + 1);

	typedef struct packed
	{
		xlen_t     pc;
		opcode_t   opcode;
		funct3_t   funct3;
		funct7_t   funct7;
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		reg_addr_t rd_addr;
		xlen_t     rs1_data;
		xlen_t     rs2_data;
		xlen_t     imm;
	} entry_t;

	entry_t           mem [INPUT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;   // Occupied entries

	// Wraps at INPUT_DEPTH, so any depth works
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(INPUT_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= '{pc, opcode, funct3, funct7, rs1_addr, rs2_addr, rd_addr,
				rs1_data, rs2_data, imm};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (buf_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({in_valid, buf_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Idle, or push and pop together
			endcase
			in_credit <= buf_pop;
		end
	end

	assign buf_valid     = (count != '0);
	assign head_pc       = mem[rd_ptr].pc;
	assign head_opcode   = mem[rd_ptr].opcode;
	assign head_funct3   = mem[rd_ptr].funct3;
	assign head_funct7   = mem[rd_ptr].funct7;
	assign head_rs1_addr = mem[rd_ptr].rs1_addr;
	assign head_rs2_addr = mem[rd_ptr].rs2_addr;
	assign head_rd_addr  = mem[rd_ptr].rd_addr;
	assign head_rs1_data = mem[rd_ptr].rs1_data;
	assign head_rs2_data = mem[rd_ptr].rs2_data;
	assign head_imm      = mem[rd_ptr].imm;

endmodule

// File: result_sender.sv
`timescale 1ns/10ps
module result_sender
#(
	parameter int OUT_CREDITS = 2
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic out_valid,
	input  logic out_credit,
	output logic can_send
);
	localparam int CNT_W = $clog2(OUT_CREDITS + 1);

	logic [CNT_W-1:0] credits;   // Credits held toward the consumer

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			credits <= CNT_W'(OUT_CREDITS);
		else
		begin
			case ({out_valid, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;   // Spend and return cancel
			endcase
		end
	end

	// A result in flight on out_valid already owns one of the credits
	assign can_send = (credits > CNT_W'(out_valid));

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_instr_exec -f verilog.f -o sim_instr_exec
./obj_dir/sim_instr_exec > sim.log 2>&1
cat sim.log
if grep -qx "All tests passed" sim.log
then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: tb_instr_exec.sv
`timescale 1ns/10ps
module tb_instr_exec import exec_pkg::*;
();
	localparam int CLK_PERIOD  = 8;
	localparam int INPUT_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int SEED        = 32'h2e1c20b0;
	localparam int N_RAND      = 240;
	localparam int N_CHAIN     = 40;
	localparam int N_TOTAL     = 24 + 2 + 8 + N_RAND + N_CHAIN;
	localparam int TIMEOUT_NS  = N_TOTAL * 50 * CLK_PERIOD;

	// Expected response of one instruction
	typedef struct packed
	{
		logic      we;
		reg_addr_t rd;
		xlen_t     data;
		logic      br_en;
		xlen_t     br_addr;
		logic      mrd;
		logic      mwr;
		xlen_t     maddr;
		xlen_t     mdata;
		funct3_t   msize;
	} result_t;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	xlen_t     pc;
	opcode_t   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	xlen_t     rs1_data;
	xlen_t     rs2_data;
	reg_addr_t in_rd_addr;
	xlen_t     imm;
	logic      in_credit;
	logic      out_valid;
	logic      rd_we;
	reg_addr_t rd_addr;
	xlen_t     rd_data;
	logic      branch_en;
	xlen_t     branch_addr;
	logic      mem_rd;
	logic      mem_wr;
	xlen_t     mem_addr;
	xlen_t     mem_data;
	funct3_t   mem_size;
	logic      out_credit = 1'b0;

	result_t   exp_q[$];
	result_t   exp_head;
	int        errors;
	int        sent_instr;
	int        recv_cnt;
	int        ups_credits;   // Credits held by the upstream side
	int        ret_cnt;
	int        sent_cnt;      // out_valid pulses seen
	int        granted_cnt;   // out_credit pulses seen
	int        pending;       // Results not yet credited back
	int        hold_cycles;
	logic      started;
	logic      fwd_ok;
	reg_addr_t fwd_rd;
	xlen_t     fwd_val;

	instr_exec_top dut
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.pc          (pc),
		.opcode      (opcode),
		.funct3      (funct3),
		.funct7      (funct7),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.in_rd_addr  (in_rd_addr),
		.imm         (imm),
		.in_credit   (in_credit),
		.out_valid   (out_valid),
		.rd_we       (rd_we),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.branch_en   (branch_en),
		.branch_addr (branch_addr),
		.mem_rd      (mem_rd),
		.mem_wr      (mem_wr),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_size    (mem_size),
		.out_credit  (out_credit)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic xlen_t sext(input xlen_t raw, input int bits);
		xlen_t up;
		up = raw << (XLEN - bits);
		return $signed(up) >>> (XLEN - bits);
	endfunction

	function automatic result_t predict(input opcode_t op, input funct3_t f3, input funct7_t f7,
		input xlen_t a, input xlen_t b, input xlen_t im, input xlen_t cur_pc, input reg_addr_t rd);
		result_t            r;
		xlen_t              src2;
		logic [SHAMT_W-1:0] sh;
		logic               legal;
		logic               writes;
		logic               taken;
		r      = '0;
		r.rd   = rd;
		src2   = (op == OP) ? b : im;
		sh     = src2[SHAMT_W-1:0];
		legal  = (op == OP_IMM) || (f7 == FN7_BASE) ||
			((f7 == FN7_ALT) && (f3 == FN3_ADD_SUB || f3 == FN3_SRL_SRA));
		writes = 1'b1;
		taken  = 1'b0;
		case (op)
			OP, OP_IMM:
			begin
				case (f3)
					FN3_ADD_SUB: r.data = (op == OP && f7 == FN7_ALT) ? a - src2 : a + src2;
					FN3_SLL:     r.data = a << sh;
					FN3_SLT:     r.data = ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
					FN3_SLTU:    r.data = (a < src2) ? 32'd1 : 32'd0;
					FN3_XOR:     r.data = a ^ src2;
					FN3_SRL_SRA:
						if (f7 == FN7_ALT)
							r.data = $signed(a) >>> sh;
						else
							r.data = a >> sh;
					FN3_OR:      r.data = a | src2;
					default:     r.data = a & src2;
				endcase
				if (!legal)
					r.data = '0;
			end
			LUI:   r.data = im;
			AUIPC: r.data = cur_pc + im;
			JAL:
			begin
				r.data    = cur_pc + xlen_t'(PC_INC);
				r.br_en   = 1'b1;
				r.br_addr = cur_pc + im;
			end
			JALR:
			begin
				r.data    = cur_pc + xlen_t'(PC_INC);
				r.br_en   = 1'b1;
				r.br_addr = (a + im) & 32'hFFFF_FFFE;
			end
			BRANCH:
			begin
				writes = 1'b0;
				case (f3)
					FN3_BEQ:  taken = (a == b);
					FN3_BNE:  taken = (a != b);
					FN3_BLT:  taken = ($signed(a) < $signed(b));
					FN3_BGE:  taken = !($signed(a) < $signed(b));
					FN3_BLTU: taken = (a < b);
					FN3_BGEU: taken = !(a < b);
					default:  taken = 1'b0;
				endcase
				r.br_en   = taken;
				r.br_addr = taken ? cur_pc + im : '0;
			end
			LOAD:
			begin
				writes  = 1'b0;
				r.mrd   = 1'b1;
				r.maddr = a + im;
				r.msize = f3;
			end
			STORE:
			begin
				writes  = 1'b0;
				r.mwr   = 1'b1;
				r.maddr = a + im;
				r.msize = f3;
				if (f3 == FN3_SB)
					r.mdata = b & 32'h0000_00FF;
				else if (f3 == FN3_SH)
					r.mdata = b & 32'h0000_FFFF;
				else
					r.mdata = b;
			end
			default: writes = 1'b0;
		endcase
		r.we = writes && (rd != '0);
		return r;
	endfunction

	task automatic check_val(input string name, input xlen_t expv, input xlen_t got);
		assert (got === expv)
		else
		begin
			errors++;
			$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expv, got);
		end
	endtask

	task automatic check_quiet();
		assert (!(out_valid || in_credit || rd_we || branch_en || mem_rd || mem_wr))
		else
		begin
			errors++;
			$display("Output strobe active before any instruction was sent, at %0d ns", $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Upstream side
	////////////////////////////////////////////////////////////
	task automatic issue(input opcode_t op, input funct3_t f3, input funct7_t f7,
		input reg_addr_t a1, input reg_addr_t a2, input reg_addr_t rd,
		input xlen_t d1, input xlen_t d2, input xlen_t im);
		result_t r;
		xlen_t   cur_pc;
		xlen_t   a;
		xlen_t   b;
		@(negedge clk);
		in_valid = 1'b0;
		while (ups_credits == 0 || ($urandom % 4) == 0)
			@(negedge clk);
		cur_pc = $urandom & 32'hFFFF_FFFC;
		a = (fwd_ok && a1 == fwd_rd) ? fwd_val : d1;   // Previous result wins
		b = (fwd_ok && a2 == fwd_rd) ? fwd_val : d2;
		r = predict(op, f3, f7, a, b, im, cur_pc, rd);
		exp_q.push_back(r);
		fwd_ok     = r.we;
		fwd_rd     = rd;
		fwd_val    = r.data;
		in_valid   = 1'b1;
		pc         = cur_pc;
		opcode     = op;
		funct3     = f3;
		funct7     = f7;
		rs1_addr   = a1;
		rs2_addr   = a2;
		in_rd_addr = rd;
		rs1_data   = d1;
		rs2_data   = d2;
		imm        = im;
		started    = 1'b1;
		sent_instr++;
	endtask

	task automatic branch_tests();
		funct3_t conds[6];
		xlen_t   lhs[4];
		xlen_t   rhs[4];
		conds = '{FN3_BEQ, FN3_BNE, FN3_BLT, FN3_BGE, FN3_BLTU, FN3_BGEU};
		lhs   = '{32'h1234_5678, 32'd5, 32'd9, 32'hFFFF_FFF0};   // Equal, smaller, larger, mixed sign
		rhs   = '{32'h1234_5678, 32'd9, 32'd5, 32'h0000_0010};
		foreach (conds[i])
			for (int k = 0; k < 4; k++)
				issue(BRANCH, conds[i], FN7_BASE, 5'd1, 5'd2, 5'd0, lhs[k], rhs[k],
					sext($urandom & ~32'd1, 13));
	endtask

	task automatic jump_tests();
		issue(JAL, 3'b000, FN7_BASE, 5'd0, 5'd0, 5'd1, 32'd0, 32'd0,
			sext($urandom & ~32'd1, 21));
		// Odd sum, so bit 0 of the target must clear
		issue(JALR, 3'b000, FN7_BASE, 5'd3, 5'd0, 5'd5, 32'h0000_4001, 32'd0, 32'h0000_0010);
	endtask

	task automatic mem_tests();
		funct3_t ld_sizes[5];
		ld_sizes = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
		foreach (ld_sizes[i])
			issue(LOAD, ld_sizes[i], FN7_BASE, 5'd6, 5'd0, 5'd7, $urandom, 32'd0,
				sext($urandom, 12));
		issue(STORE, FN3_SB, FN7_BASE, 5'd6, 5'd8, 5'd0, $urandom, 32'hA5C3_96F1,
			sext($urandom, 12));
		issue(STORE, FN3_SH, FN7_BASE, 5'd6, 5'd8, 5'd0, $urandom, 32'hA5C3_96F1,
			sext($urandom, 12));
		issue(STORE, FN3_SW, FN7_BASE, 5'd6, 5'd8, 5'd0, $urandom, 32'hA5C3_96F1,
			sext($urandom, 12));
	endtask

	task automatic send_random(input logic dependent);
		opcode_t   op;
		funct3_t   f3;
		funct7_t   f7;
		reg_addr_t a1;
		reg_addr_t a2;
		reg_addr_t rd;
		xlen_t     d1;
		xlen_t     d2;
		xlen_t     im;
		int        pick;
		pick = dependent ? int'($urandom % 9) : int'($urandom % 16);
		f3   = funct3_t'($urandom % 8);
		f7   = FN7_BASE;
		a1   = reg_addr_t'($urandom % 4);   // Small register set for many hazards
		a2   = reg_addr_t'($urandom % 4);
		rd   = reg_addr_t'($urandom % 4);
		d1   = $urandom;
		d2   = (($urandom % 4) == 0) ? d1 : $urandom;
		im   = sext($urandom, 12);
		if (dependent)
		begin
			// Stale register data that forwarding has to replace
			a1 = fwd_rd;
			a2 = (($urandom % 2) == 0) ? fwd_rd : a2;
			rd = reg_addr_t'(1 + $urandom % 7);
			d1 = 32'hBAD0_0000 | ($urandom & 32'hFFFF);
			d2 = ~d1;
		end
		if (pick <= 4)
		begin
			op = OP;
			if ((f3 == FN3_ADD_SUB || f3 == FN3_SRL_SRA) && ($urandom % 2) == 1)
				f7 = FN7_ALT;
			if (!dependent && ($urandom % 8) == 0)
				f7 = funct7_t'($urandom);   // Mostly an unused encoding
		end
		else if (pick <= 8)
		begin
			op = OP_IMM;
			if (f3 == FN3_SRL_SRA && ($urandom % 2) == 1)
				f7 = FN7_ALT;
		end
		else if (pick == 9)
		begin
			op = LUI;
			im = $urandom & 32'hFFFF_F000;
		end
		else if (pick == 10)
		begin
			op = AUIPC;
			im = $urandom & 32'hFFFF_F000;
		end
		else if (pick == 11)
		begin
			op = JAL;
			im = sext($urandom & ~32'd1, 21);
		end
		else if (pick == 12)
			op = JALR;
		else if (pick == 13)
		begin
			op = BRANCH;
			if (f3 == 3'b010 || f3 == 3'b011)
				f3 = f3 + 3'd2;
			im = sext($urandom & ~32'd1, 13);
		end
		else if (pick == 14)
		begin
			op = LOAD;
			if (f3 == 3'b011 || f3 > 3'b101)
				f3 = 3'b010;
		end
		else
		begin
			op = STORE;
			f3 = funct3_t'($urandom % 3);
		end
		issue(op, f3, f7, a1, a2, rd, d1, d2, im);
	endtask

	// Credit bookkeeping on both sides
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			ups_credits <= INPUT_DEPTH;
			ret_cnt     <= 0;
			sent_cnt    <= 0;
			granted_cnt <= 0;
		end
		else
		begin
			ups_credits <= ups_credits + int'(in_credit) - int'(in_valid);
			ret_cnt     <= ret_cnt + int'(in_credit);
			sent_cnt    <= sent_cnt + int'(out_valid);
			granted_cnt <= granted_cnt + int'(out_credit);
		end
	end

	////////////////////////////////////////////////////////////
	// Consumer side
	////////////////////////////////////////////////////////////
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			out_credit = 1'b0;
			if (out_valid)
			begin
				assert (exp_q.size() != 0)
				else
				begin
					errors++;
					$display("Result received with no instruction outstanding, at %0d ns", $time);
				end
				if (exp_q.size() != 0)
				begin
					exp_head = exp_q.pop_front();
					check_val("rd_we", xlen_t'(exp_head.we), xlen_t'(rd_we));
					check_val("rd_addr", xlen_t'(exp_head.rd), xlen_t'(rd_addr));
					if (exp_head.we)
						check_val("rd_data", exp_head.data, rd_data);
					check_val("branch_en", xlen_t'(exp_head.br_en), xlen_t'(branch_en));
					check_val("branch_addr", exp_head.br_addr, branch_addr);
					check_val("mem_rd", xlen_t'(exp_head.mrd), xlen_t'(mem_rd));
					check_val("mem_wr", xlen_t'(exp_head.mwr), xlen_t'(mem_wr));
					if (exp_head.mrd || exp_head.mwr)
					begin
						check_val("mem_addr", exp_head.maddr, mem_addr);
						check_val("mem_size", xlen_t'(exp_head.msize), xlen_t'(mem_size));
					end
					if (exp_head.mwr)
						check_val("mem_data", exp_head.mdata, mem_data);
				end
				recv_cnt++;
				pending++;
			end
			// Long stretches without credits now and then
			if (hold_cycles > 0)
				hold_cycles--;
			else if (($urandom % 40) == 0)
				hold_cycles = 20 + int'($urandom % 40);
			else if (pending > 0 && ($urandom % 3) == 0)
			begin
				out_credit = 1'b1;
				pending--;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !(out_valid || in_credit || rd_we || branch_en || mem_rd || mem_wr))
	else
	begin
		errors++;
		$display("Output strobe active before any instruction was sent, at %0d ns", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> !(rd_we || branch_en || mem_rd || mem_wr))
	else
	begin
		errors++;
		$display("Result strobe active without out_valid, at %0d ns", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (sent_cnt < OUT_CREDITS + granted_cnt))
	else
	begin
		errors++;
		$display("Result sent without an output credit, at %0d ns", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n) ups_credits <= INPUT_DEPTH)
	else
	begin
		errors++;
		$display("More input credits returned than entries used, at %0d ns", $time);
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		void'($urandom(SEED));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		pc         = '0;
		opcode     = OP;
		funct3     = '0;
		funct7     = '0;
		rs1_addr   = '0;
		rs2_addr   = '0;
		rs1_data   = '0;
		rs2_data   = '0;
		in_rd_addr = '0;
		imm        = '0;
		started    = 1'b0;
		fwd_ok     = 1'b0;
		fwd_rd     = '0;
		fwd_val    = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (5)
		begin
			@(negedge clk);
			check_quiet();
		end
		branch_tests();
		jump_tests();
		mem_tests();
		repeat (N_RAND) send_random(1'b0);
		repeat (N_CHAIN) send_random(1'b1);
		@(negedge clk);
		in_valid = 1'b0;
		wait (recv_cnt == sent_instr);
		repeat (INPUT_DEPTH + 4) @(negedge clk);
		check_val("in_credit pulses", xlen_t'(sent_instr), xlen_t'(ret_cnt));
		check_val("upstream credits", xlen_t'(INPUT_DEPTH), xlen_t'(ups_credits));
		check_val("outstanding results", 32'd0, xlen_t'(exp_q.size()));
		$display("Run complete: %0d errors, %0d instructions sent, %0d results received",
			errors, sent_instr, recv_cnt);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns with %0d of %0d results received",
			TIMEOUT_NS, recv_cnt, sent_instr);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: verilog.f
exec_pkg.sv
issue_buffer.sv
alu_unit.sv
branch_mem_unit.sv
exec_stage.sv
result_sender.sv
instr_exec_top.sv
tb_instr_exec.sv
